// File: Bender.yml
package:
  name: huff_encoder

sources:
  - include_dirs:
      - src
    files:
      - src/huff_pkg.sv
      - src/huff_bit_if.sv
      - src/huff_code_table.sv
      - src/huff_ctrl_regs.sv
      - src/huff_translator.sv
      - src/huff_bit_packer.sv
      - src/huff_encoder_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/huff_encoder_assert.sv
      - verif/huff_encoder_tb.sv

// File: huff_encoder.f
+incdir+src
src/huff_pkg.sv
src/huff_bit_if.sv
src/huff_code_table.sv
src/huff_ctrl_regs.sv
src/huff_translator.sv
src/huff_bit_packer.sv
src/huff_encoder_top.sv
verif/huff_encoder_assert.sv
verif/huff_encoder_tb.sv

// File: src/huff_bit_if.sv
`timescale 1ns/1ps

// serial code-bit stream between the translator and the packer.
// a bit moves on a rising edge where valid and ready are both high.
interface huff_bit_if;

    logic valid;
    logic ready;
    logic code_bit;
    logic last;

    modport source (
        output valid,
        output code_bit,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  code_bit,
        input  last,
        output ready
    );

endinterface

// File: src/huff_bit_packer.sv
`timescale 1ns/1ps
`include "huff_defines.svh"

module huff_bit_packer (
    input  logic                    clk,
    input  logic                    rst,
    huff_bit_if.sink                bits,
    output logic                    out_valid,
    output logic [`HUFF_CHAR_W-1:0] out_data,
    output logic                    out_last,
    input  logic                    out_ready
);

    logic [`HUFF_CHAR_W-1:0]         acc_q;
    logic [`HUFF_CHAR_W-1:0]         acc_next;
    logic [$clog2(`HUFF_CHAR_W)-1:0] fill_q;
    logic                            bit_xfer;
    logic                            flush;

    // the output byte register drains in the same cycle it is refilled.
    assign bits.ready = !out_valid || out_ready;
    assign bit_xfer   = bits.valid && bits.ready;
    assign flush      = bit_xfer && (bits.last || (fill_q == '1));

    // bits land msb first, so the inverted fill count is the bit position.
    // positions not yet written stay zero and pad a short final byte.
    always_comb begin
        acc_next = acc_q;
        acc_next[~fill_q] = bits.code_bit;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_q     <= '0;
            fill_q    <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
                out_last  <= 1'b0;
            end
            if (flush) begin
                acc_q     <= '0;
                fill_q    <= '0;
                out_valid <= 1'b1;
                out_last  <= bits.last;
            end else if (bit_xfer) begin
                acc_q  <= acc_next;
                fill_q <= fill_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            out_data <= acc_next;
        end
    end

endmodule

// File: src/huff_code_table.sv
`timescale 1ns/1ps
`include "huff_defines.svh"

module huff_code_table (
    input  logic                    clk,
    input  logic                    rst,

    // host write port.
    input  logic                    tbl_wr,
    input  logic [`HUFF_CHAR_W-1:0] tbl_char,
    input  logic [`HUFF_PATH_W-1:0] tbl_path,

    // lookup port, read data follows rd_en by one cycle.
    input  logic                    rd_en,
    input  logic [`HUFF_CHAR_W-1:0] rd_char,
    output logic [`HUFF_PATH_W-1:0] rd_path
);

    // one path word per byte value.
    logic [`HUFF_PATH_W-1:0] mem [`HUFF_TBL_DEPTH];

    always_ff @(posedge clk) begin
        if (tbl_wr) begin
            mem[tbl_char] <= tbl_path;
        end
    end

    // registered read.
    // the translator samples rd_path in the cycle after it issues rd_en.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_path <= '0;
        end else if (rd_en) begin
            rd_path <= mem[rd_char];
        end
    end

endmodule

// File: src/huff_ctrl_regs.sv
`timescale 1ns/1ps
`include "huff_defines.svh"

module huff_ctrl_regs
    import huff_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        cfg_wr,
    input  logic [`HUFF_CFG_ADDR_W-1:0] cfg_addr,
    input  logic [`HUFF_CFG_DATA_W-1:0] cfg_wdata,
    output logic [`HUFF_CFG_DATA_W-1:0] cfg_rdata,

    input  logic                        run_end,
    output logic                        run_start,
    output logic [`HUFF_COUNT_W-1:0]    total_count
);

    logic busy;
    logic done;
    logic start_wr;
    logic total_wr;

    // a start or a count write has no effect while a run is in progress.
    assign start_wr = cfg_wr && (cfg_addr_t'(cfg_addr) == REG_CTRL) && cfg_wdata[0] && !busy;
    assign total_wr = cfg_wr && (cfg_addr_t'(cfg_addr) == REG_TOTAL) && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            done        <= 1'b0;
            run_start   <= 1'b0;
            total_count <= '0;
        end else begin
            run_start <= start_wr;
            if (total_wr) begin
                total_count <= cfg_wdata;
            end
            if (start_wr) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (run_end) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr_t'(cfg_addr))
            REG_STATUS: cfg_rdata = {{(`HUFF_CFG_DATA_W-2){1'b0}}, done, busy};
            REG_TOTAL:  cfg_rdata = total_count;
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

// File: src/huff_defines.svh
`ifndef HUFF_DEFINES_SVH
`define HUFF_DEFINES_SVH

// character and table geometry.
`define HUFF_CHAR_W      8
`define HUFF_TBL_DEPTH   256

// a path word holds the code bits behind one leading sentinel one.
`define HUFF_PATH_W      128
`define HUFF_PATH_IDX_W  7

// the header carries the total character count, msb first.
`define HUFF_COUNT_W     32
`define HUFF_EOF_CHAR    8'h1A

// host register port.
`define HUFF_CFG_ADDR_W  2
`define HUFF_CFG_DATA_W  32
`define HUFF_REG_CTRL    2'd0
`define HUFF_REG_STATUS  2'd1
`define HUFF_REG_TOTAL   2'd2

`endif

// File: src/huff_encoder_top.sv
`timescale 1ns/1ps
`include "huff_defines.svh"

module huff_encoder_top (
    input  logic                        clk,
    input  logic                        rst,

    // character stream.
    input  logic                        char_valid,
    output logic                        char_ready,
    input  logic [`HUFF_CHAR_W-1:0]     char_data,

    // packed byte stream.
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [`HUFF_CHAR_W-1:0]     out_data,
    output logic                        out_last,

    // host register port.
    input  logic                        cfg_wr,
    input  logic                        cfg_rd,
    input  logic [`HUFF_CFG_ADDR_W-1:0] cfg_addr,
    input  logic [`HUFF_CFG_DATA_W-1:0] cfg_wdata,
    output logic [`HUFF_CFG_DATA_W-1:0] cfg_rdata,

    // code table load port.
    input  logic                        tbl_wr,
    input  logic [`HUFF_CHAR_W-1:0]     tbl_char,
    input  logic [`HUFF_PATH_W-1:0]     tbl_path
);

    logic                        run_start;
    logic                        run_end;
    logic [`HUFF_COUNT_W-1:0]    total_count;
    logic                        rd_en;
    logic [`HUFF_CHAR_W-1:0]     rd_char;
    logic [`HUFF_PATH_W-1:0]     rd_path;
    logic [`HUFF_CFG_DATA_W-1:0] regs_rdata;

    huff_bit_if code_bits ();

    // read data is only driven while the host strobes cfg_rd.
    assign cfg_rdata = cfg_rd ? regs_rdata : '0;

    huff_ctrl_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (regs_rdata),
        .run_end     (run_end),
        .run_start   (run_start),
        .total_count (total_count)
    );

    huff_code_table u_table (
        .clk      (clk),
        .rst      (rst),
        .tbl_wr   (tbl_wr),
        .tbl_char (tbl_char),
        .tbl_path (tbl_path),
        .rd_en    (rd_en),
        .rd_char  (rd_char),
        .rd_path  (rd_path)
    );

    huff_translator u_translator (
        .clk         (clk),
        .rst         (rst),
        .run_start   (run_start),
        .total_count (total_count),
        .char_valid  (char_valid),
        .char_data   (char_data),
        .char_ready  (char_ready),
        .rd_en       (rd_en),
        .rd_char     (rd_char),
        .rd_path     (rd_path),
        .bits        (code_bits),
        .run_end     (run_end)
    );

    huff_bit_packer u_packer (
        .clk       (clk),
        .rst       (rst),
        .bits      (code_bits),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

// File: src/huff_pkg.sv
`include "huff_defines.svh"

package huff_pkg;

    // translator states.
    // the final bit of the header or of a code waits in FETCH until the
    // next character shows whether it must carry last.
    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        FETCH,
        LOOKUP,
        SEEK,
        EMIT,
        FINISH
    } trans_state_t;

    // host register map.
    typedef enum logic [`HUFF_CFG_ADDR_W-1:0] {
        REG_CTRL   = `HUFF_REG_CTRL,
        REG_STATUS = `HUFF_REG_STATUS,
        REG_TOTAL  = `HUFF_REG_TOTAL
    } cfg_addr_t;

endpackage

// File: src/huff_translator.sv
`timescale 1ns/1ps
`include "huff_defines.svh"

module huff_translator
    import huff_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     run_start,
    input  logic [`HUFF_COUNT_W-1:0] total_count,

    input  logic                     char_valid,
    input  logic [`HUFF_CHAR_W-1:0]  char_data,
    output logic                     char_ready,

    output logic                     rd_en,
    output logic [`HUFF_CHAR_W-1:0]  rd_char,
    input  logic [`HUFF_PATH_W-1:0]  rd_path,

    huff_bit_if.source               bits,
    output logic                     run_end
);

    trans_state_t state;

    logic [$clog2(`HUFF_COUNT_W)-1:0] hdr_idx;
    logic [`HUFF_PATH_IDX_W-1:0]      idx;
    logic [`HUFF_PATH_W-1:0]          path_q;
    logic                             pend;
    logic                             pend_bit;
    logic                             char_take;
    logic                             bit_xfer;

    assign char_ready = (state == FETCH);
    assign char_take  = char_valid && char_ready;
    assign rd_en      = char_take && (char_data != `HUFF_EOF_CHAR);
    assign rd_char    = char_data;
    assign bit_xfer   = bits.valid && bits.ready;

    // FINISH always presents the last-marked bit.
    assign run_end = (state == FINISH) && bits.ready;

    // the held final bit goes out first, during the lookup of the next
    // character, and only then the new code bits.
    always_comb begin
        bits.valid    = 1'b0;
        bits.code_bit = pend_bit;
        bits.last     = 1'b0;
        case (state)
            HEADER: begin
                bits.valid    = 1'b1;
                bits.code_bit = total_count[hdr_idx];
            end
            LOOKUP, SEEK: begin
                bits.valid = pend;
            end
            EMIT: begin
                // bit 0 of the path is not sent here but moved into pend.
                bits.valid = pend || (idx != '0);
                if (!pend) begin
                    bits.code_bit = path_q[idx];
                end
            end
            FINISH: begin
                bits.valid = 1'b1;
                bits.last  = 1'b1;
            end
            default: begin
                bits.valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            hdr_idx <= '0;
            idx     <= '0;
            pend    <= 1'b0;
        end else begin
            if (pend && bit_xfer) begin
                pend <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (run_start) begin
                        hdr_idx <= '1;
                        state   <= HEADER;
                    end
                end
                HEADER: begin
                    if (bit_xfer) begin
                        hdr_idx <= hdr_idx - 1'b1;
                        if (hdr_idx == 'd1) begin
                            pend  <= 1'b1;
                            state <= FETCH;
                        end
                    end
                end
                FETCH: begin
                    if (char_take) begin
                        state <= rd_en ? LOOKUP : FINISH;
                    end
                end
                LOOKUP: begin
                    // a sentinel in the top bit needs no search.
                    idx   <= {{(`HUFF_PATH_IDX_W-1){1'b1}}, 1'b0};
                    state <= rd_path[`HUFF_PATH_W-1] ? EMIT : SEEK;
                end
                SEEK: begin
                    idx <= idx - 1'b1;
                    if (idx == '0) begin
                        state <= FETCH;
                    end else if (path_q[idx]) begin
                        state <= EMIT;
                    end
                end
                EMIT: begin
                    if (!pend) begin
                        if (idx == '0) begin
                            pend  <= 1'b1;
                            state <= FETCH;
                        end else if (bit_xfer) begin
                            idx <= idx - 1'b1;
                        end
                    end
                end
                FINISH: begin
                    if (bit_xfer) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            path_q <= rd_path;
        end
        if ((state == HEADER) && bit_xfer && (hdr_idx == 'd1)) begin
            pend_bit <= total_count[0];
        end else if ((state == EMIT) && !pend && (idx == '0)) begin
            pend_bit <= path_q[0];
        end
    end

endmodule

// File: verif/huff_encoder_assert.sv
`timescale 1ns/1ps
`include "huff_defines.svh"

module huff_encoder_assert
    import huff_pkg::*;
(
    input logic                    clk,
    input logic                    rst,
    input logic                    char_valid,
    input logic                    char_ready,
    input logic                    out_valid,
    input logic                    out_ready,
    input logic [`HUFF_CHAR_W-1:0] out_data,
    input logic                    out_last,
    input logic                    bit_valid,
    input logic                    bit_ready,
    input logic                    code_bit,
    input logic                    bit_last,
    input trans_state_t            state,
    input logic                    busy,
    input logic                    done,
    input logic                    run_start,
    input logic                    run_end
);

    int fail_count = 0;

    // the first cycle of reset may still see unknown register values.
    a_reset_state: assert property (@(posedge clk) rst && $past(rst) |->
        !char_ready && !out_valid && !out_last && !busy && !done &&
        !run_start && !run_end && !bit_valid && state == IDLE)
        else begin
            fail_count++;
            $error("outputs not cleared during reset");
        end

    a_after_reset: assert property (@(posedge clk) $fell(rst) |->
        !char_ready && !out_valid && !out_last)
        else begin
            fail_count++;
            $error("outputs not low after reset release");
        end

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else begin
            fail_count++;
            $error("output byte changed before it was accepted");
        end

    a_bit_hold: assert property (@(posedge clk) disable iff (rst)
        bit_valid && !bit_ready |=> bit_valid && $stable(code_bit) && $stable(bit_last))
        else begin
            fail_count++;
            $error("code bit changed before it was accepted");
        end

    // an accepted character is followed by its lookup, so only one is taken at a time.
    a_char_once: assert property (@(posedge clk) disable iff (rst)
        char_valid && char_ready |=> !char_ready)
        else begin
            fail_count++;
            $error("char_ready stayed high after a character was accepted");
        end

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        run_start |-> state == IDLE && busy)
        else begin
            fail_count++;
            $error("run started while a run was active");
        end

    a_busy_run: assert property (@(posedge clk) disable iff (rst)
        state != IDLE |-> busy)
        else begin
            fail_count++;
            $error("busy flag low while the translator is running");
        end

    a_run_flags: assert property (@(posedge clk) disable iff (rst)
        run_end |=> !busy && done)
        else begin
            fail_count++;
            $error("busy or done flag out of step with the end of the run");
        end

endmodule

bind huff_encoder_top huff_encoder_assert u_assert (
    .bit_valid (code_bits.valid),
    .bit_ready (code_bits.ready),
    .code_bit  (code_bits.code_bit),
    .bit_last  (code_bits.last),
    .state     (u_translator.state),
    .busy      (u_regs.busy),
    .done      (u_regs.done),
    .*
);

// File: verif/huff_encoder_tb.sv
`timescale 1ns/1ps
`include "huff_defines.svh"

module huff_encoder_tb
    import huff_pkg::*;
();

    logic                        clk;
    logic                        rst;
    logic                        char_valid;
    logic                        char_ready;
    logic [`HUFF_CHAR_W-1:0]     char_data;
    logic                        out_valid;
    logic                        out_ready;
    logic [`HUFF_CHAR_W-1:0]     out_data;
    logic                        out_last;
    logic                        cfg_wr;
    logic                        cfg_rd;
    logic [`HUFF_CFG_ADDR_W-1:0] cfg_addr;
    logic [`HUFF_CFG_DATA_W-1:0] cfg_wdata;
    logic [`HUFF_CFG_DATA_W-1:0] cfg_rdata;
    logic                        tbl_wr;
    logic [`HUFF_CHAR_W-1:0]     tbl_char;
    logic [`HUFF_PATH_W-1:0]     tbl_path;

    logic [31:0]             rng = 32'd984;
    logic [19:0]             code_val [256];
    int                      code_len [256];
    logic [`HUFF_CHAR_W-1:0] char_q [$];
    logic [`HUFF_CHAR_W-1:0] exp_q [$];
    int                      mismatch_cnt = 0;
    int                      other_cnt = 0;

    huff_encoder_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rand_next();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    // every byte value gets a code of 1 to 20 bits behind the sentinel one.
    task automatic load_table();
        for (int c = 0; c < 256; c++) begin
            code_len[c] = 1 + (rand_next() % 20);
            code_val[c] = 20'(rand_next() & ((32'd1 << code_len[c]) - 1));
            tbl_wr   = 1'b1;
            tbl_char = 8'(c);
            tbl_path = (128'd1 << code_len[c]) | 128'(code_val[c]);
            @(negedge clk);
        end
        tbl_wr = 1'b0;
    endtask

    task automatic build_model(input logic [31:0] total);
        bit                      bit_q [$];
        logic [`HUFF_CHAR_W-1:0] byte_v;
        for (int i = `HUFF_COUNT_W - 1; i >= 0; i--) begin
            bit_q.push_back(total[i]);
        end
        for (int k = 0; k < char_q.size(); k++) begin
            if (char_q[k] == `HUFF_EOF_CHAR) begin
                break;
            end
            for (int i = code_len[char_q[k]] - 1; i >= 0; i--) begin
                bit_q.push_back(code_val[char_q[k]][i]);
            end
        end
        while (bit_q.size() % 8 != 0) begin
            bit_q.push_back(1'b0);
        end
        exp_q.delete();
        for (int b = 0; b < bit_q.size(); b += 8) begin
            for (int i = 0; i < 8; i++) begin
                byte_v = {byte_v[6:0], bit_q[b+i]};
            end
            exp_q.push_back(byte_v);
        end
    endtask

    // char_ready depends only on the translator state, so it is stable here.
    task automatic send_chars(input string name);
        int wait_cnt;
        for (int k = 0; k < char_q.size(); k++) begin
            char_valid = 1'b1;
            char_data  = char_q[k];
            wait_cnt   = 0;
            while (!char_ready && wait_cnt < 4000) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (!char_ready) begin
                other_cnt++;
                $display("%s: timeout waiting for char_ready at character %0d", name, k);
                break;
            end
            @(negedge clk);
        end
        char_valid = 1'b0;
    endtask

    task automatic collect_bytes(input string name);
        int idx;
        int idle;
        bit got_last;
        idx      = 0;
        idle     = 0;
        got_last = 1'b0;
        while (!got_last && idle < 4000) begin
            @(negedge clk);
            out_ready = (rand_next() % 4) != 0;
            idle++;
            if (out_valid && out_ready) begin
                idle = 0;
                if (idx >= exp_q.size()) begin
                    other_cnt++;
                    $display("%s: byte %0d arrived beyond the expected stream", name, idx);
                end else begin
                    assert (out_data == exp_q[idx]) else begin
                        mismatch_cnt++;
                        $display("MISMATCH %s byte %0d expected %02h actual %02h",
                                 name, idx, exp_q[idx], out_data);
                    end
                    assert (out_last == (idx == exp_q.size() - 1)) else begin
                        mismatch_cnt++;
                        $display("MISMATCH %s last of byte %0d expected %0b actual %0b",
                                 name, idx, idx == exp_q.size() - 1, out_last);
                    end
                end
                got_last = out_last;
                idx++;
            end
        end
        if (!got_last) begin
            other_cnt++;
            $display("%s: timeout waiting for the last output byte", name);
        end
        // nothing may follow the last byte.
        out_ready = 1'b1;
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            assert (!out_valid) else begin
                other_cnt++;
                $display("%s: a byte followed the last byte", name);
            end
        end
    endtask

    task automatic check_status(input string name);
        cfg_rd   = 1'b1;
        cfg_addr = REG_STATUS;
        #1;
        assert (cfg_rdata[1:0] == 2'b10) else begin
            mismatch_cnt++;
            $display("MISMATCH %s status expected 2 actual %0h", name, cfg_rdata[1:0]);
        end
        @(negedge clk);
        cfg_rd = 1'b0;
    endtask

    task automatic run_case(input string name, input int n_chars);
        logic [`HUFF_CHAR_W-1:0] ch;
        char_q.delete();
        for (int k = 0; k < n_chars; k++) begin
            ch = 8'(rand_next());
            if (ch == `HUFF_EOF_CHAR) begin
                ch = 8'h00;
            end
            char_q.push_back(ch);
        end
        char_q.push_back(`HUFF_EOF_CHAR);
        build_model(n_chars);
        cfg_write(REG_TOTAL, n_chars);
        cfg_write(REG_CTRL, 32'd1);
        // this start arrives while busy and must not restart the header.
        cfg_write(REG_CTRL, 32'd1);
        fork
            send_chars(name);
            collect_bytes(name);
        join
        check_status(name);
    endtask

    initial begin
        rst        = 1'b1;
        char_valid = 1'b0;
        char_data  = '0;
        out_ready  = 1'b0;
        cfg_wr     = 1'b0;
        cfg_rd     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        tbl_wr     = 1'b0;
        tbl_char   = '0;
        tbl_path   = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        load_table();
        run_case("random_long", 40);
        run_case("eof_first", 0);
        run_case("random_short", 3);
        $display("mismatches %0d, other errors %0d, assertion failures %0d",
                 mismatch_cnt, other_cnt, u_dut.u_assert.fail_count);
        if (mismatch_cnt + other_cnt + u_dut.u_assert.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
